// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_pu_slave_spi
FILELIST  ?= pu_slave_spi.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== pu_slave_spi.f ====
+incdir+rtl
rtl/pu_slave_spi_pkg.sv
rtl/spi_line_filter.sv
rtl/spi_byte_shifter.sv
rtl/word_to_byte_splitter.sv
rtl/byte_to_word_assembler.sv
rtl/word_fifo.sv
rtl/pu_slave_spi.sv
sim/spi_result_checker.sv
sim/tb_pu_slave_spi.sv

// ==== rtl/byte_to_word_assembler.sv ====
`timescale 1ns/1ps
`include "pu_slave_spi_params.svh"

module byte_to_word_assembler (
    input  logic                       clk,
    input  logic                       rst,
    input  pu_slave_spi_pkg::rx_byte_t rx,
    output logic                       push,
    output pu_slave_spi_pkg::word_t    word
);
    import pu_slave_spi_pkg::*;

    localparam byte_idx_t last_idx = byte_idx_t'(`PU_BYTES_PER_WORD - 1);

    byte_idx_t byte_cnt;
    word_t     acc;

    // acc is complete during the push cycle
    assign word = acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= '0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            if (rx.valid) begin
                if (byte_cnt == last_idx) begin
                    byte_cnt <= '0;
                    push     <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // first byte ends up in the top of the word
    always_ff @(posedge clk) begin
        if (rx.valid) begin
            acc <= {acc[`PU_DATA_WIDTH-`PU_SPI_BYTE_WIDTH-1:0], rx.data};
        end
    end

endmodule

// ==== rtl/pu_slave_spi.sv ====
`timescale 1ns/1ps
`include "pu_slave_spi_params.svh"

module pu_slave_spi (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    signal_cycle,
    input  logic                    signal_wr,
    input  pu_slave_spi_pkg::word_t data_in,
    input  logic                    signal_oe,
    output pu_slave_spi_pkg::word_t data_out,
    output logic                    flag_stop,
    input  logic                    cs,
    input  logic                    sclk,
    input  logic                    mosi,
    output logic                    miso
);
    import pu_slave_spi_pkg::*;

    spi_lines_t lines;
    rx_byte_t   rx;
    spi_byte_t  tx_byte;
    bank_sel_t  bank_sel;
    logic       cs_d;
    logic       swap;
    logic       stop_rst;
    logic       byte_taken;
    logic       split_pop;
    logic       asm_push;
    word_t      asm_word;
    word_t      send_head [2];
    word_t      recv_head [2];

    //////////////////////////////
    // pin filters and bit engine

    spi_line_filter #(.reset_level(1'b1)) cs_filter (
        .clk(clk), .rst(rst), .raw(cs), .clean(lines.cs)
    );
    spi_line_filter #(.reset_level(1'b0)) sclk_filter (
        .clk(clk), .rst(rst), .raw(sclk), .clean(lines.sclk)
    );
    spi_line_filter #(.reset_level(1'b0)) mosi_filter (
        .clk(clk), .rst(rst), .raw(mosi), .clean(lines.mosi)
    );

    spi_byte_shifter shifter (
        .clk(clk), .rst(rst), .lines(lines), .tx_byte(tx_byte),
        .byte_taken(byte_taken), .rx(rx), .miso(miso)
    );

    // partial words are dropped at the end of a transaction
    assign stop_rst = rst | flag_stop;

    word_to_byte_splitter splitter (
        .clk(clk), .rst(stop_rst), .head_word(send_head[~bank_sel]),
        .byte_taken(byte_taken), .tx_byte(tx_byte), .pop(split_pop)
    );

    byte_to_word_assembler assembler (
        .clk(clk), .rst(stop_rst), .rx(rx), .push(asm_push), .word(asm_word)
    );

    //////////////////////////////
    // banks

    for (genvar i = 0; i < 2; i++) begin : g_bank
        localparam bank_sel_t own = bank_sel_t'(i);

        // processor fills send bank b, spi drains the other one
        word_fifo send_fifo (
            .clk(clk), .rst(rst),
            .clear((swap | flag_stop) & (bank_sel != own)),
            .push(signal_wr & (bank_sel == own)), .push_word(data_in),
            .pop(split_pop & (bank_sel != own)),
            .head(send_head[i]), .count()
        );

        // spi fills receive bank not-b, processor reads bank b
        word_fifo recv_fifo (
            .clk(clk), .rst(rst),
            .clear(swap & (bank_sel == own)),
            .push(asm_push & (bank_sel != own)), .push_word(asm_word),
            .pop(signal_oe & (bank_sel == own)),
            .head(recv_head[i]), .count()
        );
    end

    //////////////////////////////
    // swap and stop control

    // swap only while the master is idle
    assign swap = signal_cycle & lines.cs;

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_sel  <= 1'b0;
            cs_d      <= 1'b1;
            flag_stop <= 1'b0;
        end else begin
            cs_d      <= lines.cs;
            flag_stop <= lines.cs & ~cs_d;
            if (swap) begin
                bank_sel <= ~bank_sel;
            end
        end
    end

    assign data_out = signal_oe ? recv_head[bank_sel] : '0;

endmodule

// ==== rtl/pu_slave_spi_params.svh ====
`ifndef PU_SLAVE_SPI_PARAMS_SVH
`define PU_SLAVE_SPI_PARAMS_SVH

// processor word and spi byte
`define PU_DATA_WIDTH 32
`define PU_SPI_BYTE_WIDTH 8

// words held by each bank
`define PU_BUF_DEPTH 6

// stable clocks before a line level is accepted
`define PU_FILTER_LEN 4

`define PU_BYTES_PER_WORD (`PU_DATA_WIDTH / `PU_SPI_BYTE_WIDTH)

`endif

// ==== rtl/pu_slave_spi_pkg.sv ====
`include "pu_slave_spi_params.svh"

package pu_slave_spi_pkg;

    typedef logic [`PU_DATA_WIDTH-1:0] word_t;
    typedef logic [`PU_SPI_BYTE_WIDTH-1:0] spi_byte_t;
    typedef logic [$clog2(`PU_BYTES_PER_WORD)-1:0] byte_idx_t;
    typedef logic [$clog2(`PU_BUF_DEPTH+1)-1:0] fifo_cnt_t;

    // bank owned by the processor side
    typedef logic bank_sel_t;

    typedef enum logic [1:0] {
        idle,
        shifting,
        done_byte
    } shifter_state_t;

    // filtered spi pins
    typedef struct packed {
        logic cs;
        logic sclk;
        logic mosi;
    } spi_lines_t;

    typedef struct packed {
        spi_byte_t data;
        logic      valid;
    } rx_byte_t;

endpackage

// ==== rtl/spi_byte_shifter.sv ====
`timescale 1ns/1ps
`include "pu_slave_spi_params.svh"

module spi_byte_shifter (
    input  logic                         clk,
    input  logic                         rst,
    input  pu_slave_spi_pkg::spi_lines_t lines,
    input  pu_slave_spi_pkg::spi_byte_t  tx_byte,
    output logic                         byte_taken,
    output pu_slave_spi_pkg::rx_byte_t   rx,
    output logic                         miso
);
    import pu_slave_spi_pkg::*;

    localparam int bit_w = $clog2(`PU_SPI_BYTE_WIDTH);
    localparam logic [bit_w-1:0] last_bit = bit_w'(`PU_SPI_BYTE_WIDTH - 1);

    shifter_state_t   state;
    logic             sclk_d;
    logic             sclk_rise;
    logic             sclk_fall;
    logic             load;
    logic             rx_valid;
    logic [bit_w-1:0] bit_cnt;
    spi_byte_t        tx_sr;
    spi_byte_t        rx_sr;

    assign sclk_rise = lines.sclk & ~sclk_d;
    assign sclk_fall = ~lines.sclk & sclk_d;

    // new byte on cs fall and on the falling edge after each full byte
    assign load = ~lines.cs & ((state == idle) | ((state == done_byte) & sclk_fall));

    assign miso     = (state != idle) & tx_sr[`PU_SPI_BYTE_WIDTH-1];
    assign rx.data  = rx_sr;
    assign rx.valid = rx_valid;

    //////////////////////////////
    // control

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            sclk_d     <= 1'b0;
            bit_cnt    <= '0;
            byte_taken <= 1'b0;
            rx_valid   <= 1'b0;
        end else begin
            sclk_d     <= lines.sclk;
            byte_taken <= load;
            rx_valid   <= 1'b0;
            if (lines.cs) begin
                state <= idle;
            end else if (load) begin
                state   <= shifting;
                bit_cnt <= '0;
            end else if (state == shifting && sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == last_bit) begin
                    state    <= done_byte;
                    rx_valid <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // shift registers

    always_ff @(posedge clk) begin
        if (load) begin
            tx_sr <= tx_byte;
        end else if (state == shifting && sclk_fall) begin
            tx_sr <= tx_sr << 1;
        end
        // msb first, mosi sampled on rising sclk
        if (state == shifting && sclk_rise) begin
            rx_sr <= {rx_sr[`PU_SPI_BYTE_WIDTH-2:0], lines.mosi};
        end
    end

endmodule

// ==== rtl/spi_line_filter.sv ====
`timescale 1ns/1ps
`include "pu_slave_spi_params.svh"

module spi_line_filter #(
    parameter logic reset_level = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  logic raw,
    output logic clean
);
    import pu_slave_spi_pkg::*;

    localparam int cnt_w = $clog2(`PU_FILTER_LEN + 1);
    localparam logic [cnt_w-1:0] cnt_full = cnt_w'(`PU_FILTER_LEN);

    logic [cnt_w-1:0] diff_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            clean    <= reset_level;
            diff_cnt <= '0;
        end else if (raw == clean) begin
            // any agreement restarts the count
            diff_cnt <= '0;
        end else if (diff_cnt == cnt_full) begin
            clean    <= raw;
            diff_cnt <= '0;
        end else begin
            diff_cnt <= diff_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/word_fifo.sv ====
`timescale 1ns/1ps
`include "pu_slave_spi_params.svh"

module word_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        push,
    input  pu_slave_spi_pkg::word_t     push_word,
    input  logic                        pop,
    output pu_slave_spi_pkg::word_t     head,
    output pu_slave_spi_pkg::fifo_cnt_t count
);
    import pu_slave_spi_pkg::*;

    localparam int ptr_w = $clog2(`PU_BUF_DEPTH);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(`PU_BUF_DEPTH - 1);
    localparam fifo_cnt_t full_cnt = fifo_cnt_t'(`PU_BUF_DEPTH);

    word_t            mem [`PU_BUF_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // overflow and underflow are silently dropped
    assign do_push = push & (count != full_cnt);
    assign do_pop  = pop & (count != '0);
    assign head    = (count == '0) ? '0 : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + fifo_cnt_t'(do_push) - fifo_cnt_t'(do_pop);
        end
    end

endmodule

// ==== rtl/word_to_byte_splitter.sv ====
`timescale 1ns/1ps
`include "pu_slave_spi_params.svh"

module word_to_byte_splitter (
    input  logic                        clk,
    input  logic                        rst,
    input  pu_slave_spi_pkg::word_t     head_word,
    input  logic                        byte_taken,
    output pu_slave_spi_pkg::spi_byte_t tx_byte,
    output logic                        pop
);
    import pu_slave_spi_pkg::*;

    localparam byte_idx_t last_idx = byte_idx_t'(`PU_BYTES_PER_WORD - 1);

    byte_idx_t byte_idx;
    byte_idx_t byte_pos;
    logic      last_byte;

    // index 0 picks the most significant byte
    assign byte_pos  = last_idx - byte_idx;
    assign tx_byte   = head_word[byte_pos * `PU_SPI_BYTE_WIDTH +: `PU_SPI_BYTE_WIDTH];
    assign last_byte = (byte_idx == last_idx);

    // word fully handed to the shifter
    assign pop = byte_taken & last_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_idx <= '0;
        end else if (byte_taken) begin
            if (last_byte) begin
                byte_idx <= '0;
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

endmodule

// ==== sim/spi_result_checker.sv ====
`timescale 1ns/1ps

module spi_result_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  pu_slave_spi_pkg::word_t     data_out,
    input  logic                        signal_oe,
    input  logic                        flag_stop,
    input  pu_slave_spi_pkg::word_t     exp_word,
    input  logic                        byte_chk,
    input  pu_slave_spi_pkg::spi_byte_t byte_got,
    input  pu_slave_spi_pkg::spi_byte_t byte_exp,
    input  logic                        end_check,
    input  int                          stops_exp,
    output int                          miso_errors,
    output int                          read_errors,
    output int                          stop_errors
);
    import pu_slave_spi_pkg::*;

    logic stop_d;
    int   stop_cnt;

    //////////////////////////////
    // processor read port

    always @(posedge clk) begin
        if (rst) begin
            read_errors <= 0;
        end else if (signal_oe && data_out !== exp_word) begin
            $display("** Error: data_out = 0x%h, expected 0x%h", data_out, exp_word);
            read_errors <= read_errors + 1;
        end else if (!signal_oe && data_out !== '0) begin
            // idle read port must stay at zero
            $display("** Error: data_out = 0x%h, expected 0x%h", data_out, word_t'(0));
            read_errors <= read_errors + 1;
        end
    end

    //////////////////////////////
    // bytes captured by the spi master

    always @(posedge clk) begin
        if (rst) begin
            miso_errors <= 0;
        end else if (byte_chk && byte_got !== byte_exp) begin
            $display("** Error: miso byte = 0x%h, expected 0x%h", byte_got, byte_exp);
            miso_errors <= miso_errors + 1;
        end
    end

    //////////////////////////////
    // stop pulse

    always @(posedge clk) begin
        if (rst) begin
            stop_d      <= 1'b0;
            stop_cnt    <= 0;
            stop_errors <= 0;
        end else begin
            stop_d <= flag_stop;
            if (flag_stop) begin
                stop_cnt <= stop_cnt + 1;
            end
            if (flag_stop && stop_d) begin
                $display("flag_stop stayed high for more than one clock");
                stop_errors <= stop_errors + 1;
            end else if (end_check && stop_cnt != stops_exp) begin
                $display("** Error: flag_stop pulses = 0x%h, expected 0x%h", stop_cnt, stops_exp);
                stop_errors <= stop_errors + 1;
            end
        end
    end

endmodule

// ==== sim/tb_pu_slave_spi.sv ====
`timescale 1ns/1ps
`include "pu_slave_spi_params.svh"

module tb_pu_slave_spi;
    import pu_slave_spi_pkg::*;

    localparam int num_rows    = 7;
    localparam int half_period = 8;
    localparam int read_words  = 7;
    localparam int stop_wait   = 20;
    localparam int bpw         = `PU_BYTES_PER_WORD;

    // short transaction modes
    localparam int mode_full       = 0;
    localparam int mode_cut        = 1;
    localparam int mode_busy_cycle = 2;

    typedef struct packed {
        int n_wr;
        int n_spi;
        int mode;
    } row_t;

    logic      clk;
    logic      rst;
    logic      signal_cycle;
    logic      signal_wr;
    word_t     data_in;
    logic      signal_oe;
    word_t     data_out;
    logic      flag_stop;
    logic      cs;
    logic      sclk;
    logic      mosi;
    logic      miso;
    word_t     exp_word;
    logic      byte_chk;
    spi_byte_t byte_got;
    spi_byte_t byte_exp;
    logic      end_check;
    int        stops_exp;
    int        miso_errors;
    int        read_errors;
    int        stop_errors;
    int        cycle_cnt;
    int        cycle_limit;

    row_t  rows [num_rows];
    word_t wr_data [num_rows][8];
    word_t mosi_data [num_rows][8];

    pu_slave_spi pu_slave_spi_inst (
        .clk(clk), .rst(rst), .signal_cycle(signal_cycle), .signal_wr(signal_wr),
        .data_in(data_in), .signal_oe(signal_oe), .data_out(data_out),
        .flag_stop(flag_stop), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso)
    );

    spi_result_checker result_checker (
        .clk(clk), .rst(rst), .data_out(data_out), .signal_oe(signal_oe),
        .flag_stop(flag_stop), .exp_word(exp_word), .byte_chk(byte_chk),
        .byte_got(byte_got), .byte_exp(byte_exp), .end_check(end_check),
        .stops_exp(stops_exp), .miso_errors(miso_errors),
        .read_errors(read_errors), .stop_errors(stop_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // table and expected values

    task automatic load_table();
        int r;
        int i;
        void'($urandom(32'h65ed));
        rows[0] = '{3, 3, mode_full};
        rows[1] = '{2, 4, mode_full};
        // overflow on both the send and the receive bank
        rows[2] = '{8, 7, mode_full};
        rows[3] = '{4, 2, mode_cut};
        rows[4] = '{3, 3, mode_busy_cycle};
        rows[5] = '{1, 1, mode_full};
        rows[6] = '{0, 0, mode_full};
        for (r = 0; r < num_rows; r++) begin
            for (i = 0; i < 8; i++) begin
                wr_data[r][i]   = $urandom();
                mosi_data[r][i] = $urandom();
            end
        end
    endtask

    function automatic spi_byte_t byte_of(input word_t w, input int pos);
        // pos 0 is the most significant byte
        return spi_byte_t'(w >> ((bpw - 1 - pos) * `PU_SPI_BYTE_WIDTH));
    endfunction

    // word the master should see on miso, zero once the bank runs dry
    function automatic word_t sent_word(input int r, input int w);
        int kept;
        kept = (rows[r].n_wr < `PU_BUF_DEPTH) ? rows[r].n_wr : `PU_BUF_DEPTH;
        return (w < kept) ? wr_data[r][w] : '0;
    endfunction

    function automatic word_t recv_word(input int r, input int w);
        int kept;
        kept = (rows[r].n_spi < `PU_BUF_DEPTH) ? rows[r].n_spi : `PU_BUF_DEPTH;
        return (w < kept) ? mosi_data[r][w] : '0;
    endfunction

    function automatic int timeout_cycles();
        int total;
        int r;
        total = 0;
        for (r = 0; r < num_rows; r++) begin
            total = total + 600 * (rows[r].n_spi + ((rows[r].mode == mode_cut) ? 1 : 0)) + 200;
        end
        return total * 3 / 2;
    endfunction

    //////////////////////////////
    // drivers

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic pulse_cycle();
        signal_cycle = 1'b1;
        @(negedge clk);
        signal_cycle = 1'b0;
    endtask

    // mode 0 master, msb first
    task automatic run_spi(input int r);
        int        n_bytes;
        int        k;
        int        b;
        int        wait_cnt;
        spi_byte_t out_byte;
        spi_byte_t in_byte;
        n_bytes = rows[r].n_spi * bpw;
        if (rows[r].mode == mode_cut) begin
            n_bytes = n_bytes + 2;
        end
        in_byte = '0;
        cs = 1'b0;
        wait_clocks(half_period);
        if (rows[r].mode == mode_busy_cycle) begin
            pulse_cycle();
        end
        for (k = 0; k < n_bytes; k++) begin
            out_byte = byte_of(mosi_data[r][k / bpw], k % bpw);
            for (b = 0; b < `PU_SPI_BYTE_WIDTH; b++) begin
                mosi = out_byte[`PU_SPI_BYTE_WIDTH-1];
                out_byte = out_byte << 1;
                wait_clocks(half_period);
                in_byte = {in_byte[`PU_SPI_BYTE_WIDTH-2:0], miso};
                sclk = 1'b1;
                wait_clocks(half_period);
                sclk = 1'b0;
            end
            byte_got = in_byte;
            byte_exp = byte_of(sent_word(r, k / bpw), k % bpw);
            byte_chk = 1'b1;
            @(negedge clk);
            byte_chk = 1'b0;
        end
        wait_clocks(half_period);
        cs = 1'b1;
        wait_cnt = 0;
        while (!flag_stop && wait_cnt < stop_wait) begin
            @(negedge clk);
            wait_cnt++;
        end
        @(negedge clk);
    endtask

    task automatic run_row(input int r);
        int i;
        for (i = 0; i < rows[r].n_wr; i++) begin
            signal_wr = 1'b1;
            data_in   = wr_data[r][i];
            @(negedge clk);
        end
        signal_wr = 1'b0;
        pulse_cycle();
        run_spi(r);
        pulse_cycle();
        for (i = 0; i < read_words; i++) begin
            signal_oe = 1'b1;
            exp_word  = recv_word(r, i);
            @(negedge clk);
        end
        signal_oe = 1'b0;
        @(negedge clk);
    endtask

    //////////////////////////////
    // main sequence and timeout

    initial begin
        rst          = 1'b1;
        signal_cycle = 1'b0;
        signal_wr    = 1'b0;
        data_in      = '0;
        signal_oe    = 1'b0;
        cs           = 1'b1;
        sclk         = 1'b0;
        mosi         = 1'b0;
        exp_word     = '0;
        byte_chk     = 1'b0;
        byte_got     = '0;
        byte_exp     = '0;
        end_check    = 1'b0;
        stops_exp    = 0;
        load_table();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        // one transaction per row
        stops_exp = num_rows;
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);
        $display("errors: miso %0d, read %0d, flag_stop %0d",
                 miso_errors, read_errors, stop_errors);
        if (miso_errors + read_errors + stop_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        @(posedge clk);
        cycle_limit = timeout_cycles();
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
        $display("tests failed");
        $finish;
    end

endmodule
